/* source/fm_pkg.sv */
package fm_pkg;

	localparam int num_slots = 32;
	localparam int num_ch = 8;
	localparam int addr_w = 10;
	localparam int data_w = 32;
	localparam int kind_lsb = 7;  // Register group in addr[9:7]
	localparam int idx_lsb = 2;   // Slot or channel in addr[6:2]

	// Operator role, slot index is role * 8 + channel
	typedef enum logic [1:0] {
		m1 = 2'd0,
		m2 = 2'd1,
		c1 = 2'd2,
		c2 = 2'd3
	} op_slot_e;

	typedef logic [2:0] conn_t;          // Algorithm 0..7
	typedef logic [2:0] fb_t;            // Feedback level, 0 is off
	typedef logic [19:0] phase_t;        // Phase accumulator and increment
	typedef logic [9:0] att_t;           // Attenuation, log units
	typedef logic signed [13:0] op_out_t;
	typedef logic signed [15:0] sample_t;

	typedef enum logic [2:0] {
		kind_conn = 3'd0,   // Per channel, fb in [5:3] and con in [2:0]
		kind_inc = 3'd1,    // Per slot phase increment
		kind_att = 3'd2,    // Per slot attenuation
		kind_key = 3'd3,    // Key-on, write only
		kind_sample = 3'd4  // Last mixed sample, read only
	} reg_kind_e;

	typedef enum logic [1:0] {
		resp_okay = 2'b00,
		resp_slverr = 2'b10
	} axi_resp_e;

endpackage

/* source/fm_regs.sv */
`timescale 1ns/1ns

module fm_regs (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [fm_pkg::addr_w-1:0]   awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [fm_pkg::data_w-1:0]   wdata,
	input  logic [fm_pkg::data_w/8-1:0] wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output fm_pkg::axi_resp_e           bresp,
	output logic                        bvalid,
	input  logic                        bready,
	input  logic [fm_pkg::addr_w-1:0]   araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [fm_pkg::data_w-1:0]   rdata,
	output fm_pkg::axi_resp_e           rresp,
	output logic                        rvalid,
	input  logic                        rready,
	input  logic [4:0]                  rd_slot,
	output fm_pkg::phase_t              inc,
	output fm_pkg::att_t                att,
	output fm_pkg::conn_t               con,
	output fm_pkg::fb_t                 fb,
	output logic [2:0]                  key_on_ch,
	output logic                        key_on_pulse,
	input  fm_pkg::sample_t             sample
);
	import fm_pkg::*;

	phase_t inc_mem [num_slots];
	att_t att_mem [num_slots];
	conn_t con_mem [num_ch];
	fb_t fb_mem [num_ch];

	reg_kind_e wr_kind, rd_kind;
	logic [4:0] wr_idx, rd_idx;
	logic [data_w-1:0] wr_val;
	logic wr_ok, rd_ok;

	function automatic logic addr_ok(input reg_kind_e kind, input logic [4:0] idx,
			input logic is_write);
		case (kind)
			kind_inc, kind_att: return 1'b1;
			kind_conn: return idx < num_ch;
			kind_key: return is_write && idx < num_ch;  // No readback of key-on
			kind_sample: return !is_write;
			default: return 1'b0;  // Unused groups 5..7
		endcase
	endfunction

	function automatic logic [data_w-1:0] reg_value(input reg_kind_e kind,
			input logic [4:0] idx);
		case (kind)
			kind_conn: return {26'b0, fb_mem[idx[2:0]], con_mem[idx[2:0]]};
			kind_inc: return data_w'(inc_mem[idx]);
			kind_att: return data_w'(att_mem[idx]);
			kind_sample: return data_w'(sample);  // Sign extended
			default: return '0;
		endcase
	endfunction

	// Byte lanes not strobed keep the old contents
	function automatic logic [data_w-1:0] apply_strb(input logic [data_w-1:0] old_val,
			input logic [data_w-1:0] new_val, input logic [data_w/8-1:0] strb);
		logic [data_w-1:0] res;
		res = old_val;
		for (int b = 0; b < data_w / 8; b++)
			if (strb[b])
				res[b*8 +: 8] = new_val[b*8 +: 8];
		return res;
	endfunction

	assign wr_kind = reg_kind_e'(awaddr[kind_lsb +: 3]);
	assign wr_idx = awaddr[idx_lsb +: 5];
	assign rd_kind = reg_kind_e'(araddr[kind_lsb +: 3]);
	assign rd_idx = araddr[idx_lsb +: 5];
	assign wr_ok = addr_ok(wr_kind, wr_idx, 1'b1);
	assign rd_ok = addr_ok(rd_kind, rd_idx, 1'b0);
	assign wr_val = apply_strb(reg_value(wr_kind, wr_idx), wdata, wstrb);

	// Parameter fetch for the sequencer
	assign inc = inc_mem[rd_slot];
	assign att = att_mem[rd_slot];
	assign con = con_mem[rd_slot[2:0]];
	assign fb = fb_mem[rd_slot[2:0]];

	always_ff @(posedge clk) begin
		if (reset) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= resp_okay;
			key_on_pulse <= 1'b0;
			key_on_ch <= '0;
			for (int i = 0; i < num_slots; i++) begin
				inc_mem[i] <= '0;
				att_mem[i] <= '1;  // Powers up silent
			end
			for (int i = 0; i < num_ch; i++) begin
				con_mem[i] <= '0;
				fb_mem[i] <= '0;
			end
		end else begin
			// One cycle ready pulse once both address and data are offered
			awready <= awvalid && wvalid && !awready && !bvalid;
			wready <= awvalid && wvalid && !awready && !bvalid;
			key_on_pulse <= 1'b0;
			if (bvalid && bready)
				bvalid <= 1'b0;
			if (awready) begin  // Handshake cycle
				bvalid <= 1'b1;
				bresp <= wr_ok ? resp_okay : resp_slverr;
				if (wr_ok) begin
					case (wr_kind)
						kind_conn: begin
							con_mem[wr_idx[2:0]] <= wr_val[2:0];
							fb_mem[wr_idx[2:0]] <= wr_val[5:3];
						end
						kind_inc: inc_mem[wr_idx] <= wr_val[19:0];
						kind_att: att_mem[wr_idx] <= wr_val[9:0];
						kind_key: begin
							key_on_pulse <= 1'b1;
							key_on_ch <= wr_idx[2:0];
						end
						default: ;
					endcase
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rresp <= resp_okay;
		end else begin
			arready <= arvalid && !arready && !rvalid;
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (arready) begin
				rvalid <= 1'b1;
				rresp <= rd_ok ? resp_okay : resp_slverr;
			end
		end
	end

	always_ff @(posedge clk)
		if (arready)
			rdata <= rd_ok ? reg_value(rd_kind, rd_idx) : '0;  // Held until next accept

endmodule

/* source/fm_slot_sequencer.sv */
`timescale 1ns/1ns

module fm_slot_sequencer (
	input  logic             clk,
	input  logic             reset,
	input  logic [2:0]       key_on_ch,
	input  logic             key_on_pulse,
	input  fm_pkg::phase_t   inc,
	input  fm_pkg::att_t     att,
	input  fm_pkg::conn_t    con,
	input  fm_pkg::fb_t      fb,
	output logic [4:0]       rd_slot,
	output logic [4:0]       slot,
	output fm_pkg::op_slot_e cur_op,
	output fm_pkg::conn_t    con_out,
	output fm_pkg::fb_t      fb_out,
	output fm_pkg::att_t     att_out,
	output fm_pkg::phase_t   phase_cnt
);
	import fm_pkg::*;

	logic [4:0] cnt;
	phase_t acc [num_slots];
	logic [num_ch-1:0] pending;    // Key-on seen, waiting for slot 0
	logic [num_ch-1:0] clr_frame;  // Channels cleared in this frame
	logic [num_ch-1:0] clr_now;
	logic [num_ch-1:0] key_mask;
	phase_t cur_phase;

	assign rd_slot = cnt;
	assign key_mask = key_on_pulse ? num_ch'(1) << key_on_ch : '0;
	assign clr_now = (cnt == '0) ? pending : clr_frame;
	assign cur_phase = clr_now[cnt[2:0]] ? '0 : acc[cnt];

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
			pending <= '0;
			clr_frame <= '0;
			slot <= '0;
			cur_op <= m1;
			con_out <= '0;
			fb_out <= '0;
			att_out <= '1;
			phase_cnt <= '0;
			for (int i = 0; i < num_slots; i++)
				acc[i] <= '0;
		end else begin
			cnt <= cnt + 5'd1;
			pending <= ((cnt == '0) ? '0 : pending) | key_mask;
			clr_frame <= clr_now;
			acc[cnt] <= cur_phase + inc;  // Stored phase moves on by one step
			slot <= cnt;
			cur_op <= op_slot_e'(cnt[4:3]);
			con_out <= con;
			fb_out <= fb;
			att_out <= att;
			phase_cnt <= cur_phase;
		end
	end

endmodule

/* source/fm_delay_line.sv */
`timescale 1ns/1ns

module fm_delay_line #(
	parameter int width = 8,
	parameter int stages = 2
) (
	input  logic             clk,
	input  logic             en,
	input  logic [width-1:0] din,
	output logic [width-1:0] dout
);

	logic [width-1:0] sr [stages];

	always_ff @(posedge clk) begin
		if (en) begin  // Holds contents otherwise
			sr[0] <= din;
			for (int i = 1; i < stages; i++)
				sr[i] <= sr[i-1];
		end
	end

	assign dout = sr[stages-1];

endmodule

/* source/fm_tables.sv */
`timescale 1ns/1ns

module fm_tables (
	input  logic [7:0]  sin_addr,
	output logic [11:0] log_sin,
	input  logic [7:0]  exp_addr,
	output logic [12:0] exp_val
);

	logic [11:0] sin_rom [256];  // -log2(sin) in 1/256 steps, quarter wave
	logic [12:0] exp_rom [256];  // Mantissa of 2^-x

	initial begin
		real ang;
		real lg;
		for (int i = 0; i < 256; i++) begin
			ang = (real'(i) + 0.5) / 256.0 * (3.14159265358979 / 2.0);  // Mid-point of step
			lg = -$ln($sin(ang)) / $ln(2.0) * 256.0;
			sin_rom[i] = 12'($rtoi(lg + 0.5));
			exp_rom[i] = 13'($rtoi(8191.0 * $pow(2.0, -real'(i) / 256.0) + 0.5));
		end
	end

	assign log_sin = sin_rom[sin_addr];
	assign exp_val = exp_rom[exp_addr];

endmodule

/* source/fm_operator.sv */
`timescale 1ns/1ns

module fm_operator (
	input  logic             clk,
	input  fm_pkg::phase_t   phase_cnt,
	input  fm_pkg::conn_t    con,
	input  fm_pkg::op_slot_e cur_op,
	input  logic [4:0]       slot,
	input  fm_pkg::fb_t      fb,
	input  fm_pkg::att_t     att,
	output fm_pkg::op_out_t  op_out,
	output logic [4:0]       out_slot
);
	import fm_pkg::*;

	localparam int hist_len = 27;  // Reaches back to the same slot of last frame

	op_out_t mod_hist [hist_len];  // Entry k holds the output of slot s-6-k
	op_out_t d8, d16, d24, d32, fb_old;
	op_out_t mod_a, mod_b;
	logic signed [14:0] mod_sum;
	logic signed [19:0] modulation;
	logic use_fb;
	phase_t phase_sum;

	logic [9:0] phase_II;
	att_t att_II, att_III;
	logic [7:0] sin_addr_III, exp_addr_IV;
	logic [11:0] log_sin;
	logic [12:0] log_sum;
	logic [4:0] shift_IV, shift_V;
	logic [12:0] exp_val, exp_V, abs_VI;
	logic sign_III, sign_IV, sign_V, sign_VI;
	op_out_t abs_ext;

	logic [9:0] ctl_VII;
	conn_t con_VII;
	op_slot_e op_VII;
	logic [4:0] slot_VII, slot_VIII;
	logic carrier;
	op_out_t op_VIII;

	assign d8 = mod_hist[2];    // One role back
	assign d16 = mod_hist[10];  // Two roles back
	assign d24 = mod_hist[18];  // Three roles back
	assign d32 = mod_hist[26];  // Own output, previous frame

	// Second feedback tap, shifts once per channel at m1
	fm_delay_line #(.width(14), .stages(8)) u_fb_dly (
		.clk  (clk),
		.en   (cur_op == m1),
		.din  (d32),
		.dout (fb_old)
	);

	// Routing follows the role order m1, m2, c1, c2 within a frame
	always_comb begin
		mod_a = '0;
		mod_b = '0;
		use_fb = 1'b0;
		case (cur_op)
			m1: begin
				mod_a = d32;
				mod_b = fb_old;
				use_fb = 1'b1;
			end
			m2: case (con)
				3'd0, 3'd2: mod_a = d24;  // C1 of last frame
				3'd1: begin
					mod_a = d24;
					mod_b = d8;  // Plus M1
				end
				3'd5: mod_a = d8;  // M1
				default: ;
			endcase
			c1: case (con)
				3'd0, 3'd3, 3'd4, 3'd5, 3'd6: mod_a = d16;  // M1
				default: ;
			endcase
			c2: case (con)
				3'd0, 3'd1, 3'd4: mod_a = d16;  // M2
				3'd2: begin
					mod_a = d24;  // M1 + M2
					mod_b = d16;
				end
				3'd3: begin
					mod_a = d8;  // C1 + M2
					mod_b = d16;
				end
				3'd5: mod_a = d24;  // M1
				default: ;
			endcase
		endcase
		mod_sum = mod_a + mod_b;
		if (use_fb)
			modulation = (fb == '0) ? '0 : 20'(mod_sum) << fb;
		else
			modulation = 20'(mod_sum) << 9;
	end

	assign phase_sum = phase_cnt + phase_t'(modulation);

	fm_tables u_tables (
		.sin_addr (sin_addr_III),
		.log_sin  (log_sin),
		.exp_addr (exp_addr_IV),
		.exp_val  (exp_val)
	);

	assign log_sum = {1'b0, log_sin} + {1'b0, att_III, 2'b00};  // Attenuation in 1/64 steps
	assign abs_ext = {1'b0, abs_VI};

	always_ff @(posedge clk) begin
		phase_II <= phase_sum[19:10];  // I
		att_II <= att;
		sin_addr_III <= phase_II[8] ? ~phase_II[7:0] : phase_II[7:0];  // II, quarter fold
		sign_III <= phase_II[9];
		att_III <= att_II;
		exp_addr_IV <= log_sum[7:0];  // III
		shift_IV <= log_sum[12:8];
		sign_IV <= sign_III;
		exp_V <= exp_val;  // IV
		shift_V <= shift_IV;
		sign_V <= sign_IV;
		abs_VI <= (shift_V < 5'd13) ? exp_V >> shift_V : '0;  // V
		sign_VI <= sign_V;
		mod_hist[0] <= sign_VI ? -abs_ext : abs_ext;  // VI, negative half-wave
		for (int k = 1; k < hist_len; k++)
			mod_hist[k] <= mod_hist[k-1];
	end

	// Role, algorithm and slot follow the data to VII
	fm_delay_line #(.width(10), .stages(6)) u_ctl_dly (
		.clk  (clk),
		.en   (1'b1),
		.din  ({con, cur_op, slot}),
		.dout (ctl_VII)
	);

	assign con_VII = ctl_VII[9:7];
	assign op_VII = op_slot_e'(ctl_VII[6:5]);
	assign slot_VII = ctl_VII[4:0];

	always_comb begin
		case (con_VII)
			3'd0, 3'd1, 3'd2, 3'd3: carrier = (op_VII == c2);
			3'd4: carrier = (op_VII == c1) || (op_VII == c2);
			3'd5, 3'd6: carrier = (op_VII != m1);
			default: carrier = 1'b1;  // All four audible
		endcase
	end

	always_ff @(posedge clk) begin
		op_VIII <= carrier ? mod_hist[0] : '0;  // VII
		slot_VIII <= slot_VII;
		op_out <= op_VIII;  // VIII
		out_slot <= slot_VIII;
	end

endmodule

/* source/fm_mixer.sv */
`timescale 1ns/1ns

module fm_mixer (
	input  logic            clk,
	input  logic            reset,
	input  fm_pkg::op_out_t op_out,
	input  logic [4:0]      out_slot,
	output fm_pkg::sample_t sample,
	output logic            sample_valid
);
	import fm_pkg::*;

	localparam int acc_w = 19;  // 32 full scale outputs fit
	localparam logic signed [acc_w-1:0] max_val = 32767;
	localparam logic signed [acc_w-1:0] min_val = -32768;

	logic signed [acc_w-1:0] sum, base, total;
	logic last;
	sample_t clamped;

	assign last = (out_slot == 5'(num_slots - 1));
	assign base = (out_slot == '0) ? '0 : sum;  // Fresh start each frame
	assign total = base + op_out;

	always_comb begin
		if (total > max_val)
			clamped = 16'sh7fff;
		else if (total < min_val)
			clamped = -16'sh8000;
		else
			clamped = total[15:0];
	end

	always_ff @(posedge clk)
		sum <= total;

	always_ff @(posedge clk) begin
		if (reset) begin
			sample <= '0;
			sample_valid <= 1'b0;
		end else begin
			sample_valid <= last;  // One pulse per frame
			if (last)
				sample <= clamped;
		end
	end

endmodule

/* source/fm_top.sv */
`timescale 1ns/1ns

module fm_top (
	input  logic                        clk,
	input  logic                        reset,
	input  logic [fm_pkg::addr_w-1:0]   awaddr,
	input  logic                        awvalid,
	output logic                        awready,
	input  logic [fm_pkg::data_w-1:0]   wdata,
	input  logic [fm_pkg::data_w/8-1:0] wstrb,
	input  logic                        wvalid,
	output logic                        wready,
	output fm_pkg::axi_resp_e           bresp,
	output logic                        bvalid,
	input  logic                        bready,
	input  logic [fm_pkg::addr_w-1:0]   araddr,
	input  logic                        arvalid,
	output logic                        arready,
	output logic [fm_pkg::data_w-1:0]   rdata,
	output fm_pkg::axi_resp_e           rresp,
	output logic                        rvalid,
	input  logic                        rready,
	output fm_pkg::sample_t             sample,
	output logic                        sample_valid
);
	import fm_pkg::*;

	logic [4:0] rd_slot, slot, out_slot;
	phase_t inc, phase_cnt;
	att_t att_r, att_s;
	conn_t con_r, con_s;
	fb_t fb_r, fb_s;
	op_slot_e cur_op;
	logic [2:0] key_on_ch;
	logic key_on_pulse;
	op_out_t op_out;

	fm_regs u_regs (
		.clk, .reset,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.rd_slot, .inc, .att (att_r), .con (con_r), .fb (fb_r),
		.key_on_ch, .key_on_pulse, .sample
	);

	fm_slot_sequencer u_seq (
		.clk, .reset, .key_on_ch, .key_on_pulse,
		.inc, .att (att_r), .con (con_r), .fb (fb_r),
		.rd_slot, .slot, .cur_op,
		.con_out (con_s), .fb_out (fb_s), .att_out (att_s), .phase_cnt
	);

	fm_operator u_op (
		.clk, .phase_cnt, .con (con_s), .cur_op, .slot, .fb (fb_s), .att (att_s),
		.op_out, .out_slot
	);

	fm_mixer u_mix (
		.clk, .reset, .op_out, .out_slot, .sample, .sample_valid
	);

endmodule

/* dv/fm_checker.sv */
`timescale 1ns/1ns

module fm_checker (
	input logic                      clk,
	input logic                      reset,
	input logic                      awready,
	input logic                      wready,
	input logic                      bvalid,
	input logic                      bready,
	input fm_pkg::axi_resp_e         bresp,
	input logic                      arready,
	input logic                      rvalid,
	input logic                      rready,
	input fm_pkg::axi_resp_e         rresp,
	input logic [fm_pkg::data_w-1:0] rdata,
	input logic                      sample_valid
);

	int unsigned fail_count = 0;
	logic [5:0] gap;  // Cycles since last sample strobe
	logic seen;

	always_ff @(posedge clk) begin
		if (reset) begin
			gap <= '0;
			seen <= 1'b0;
		end else if (sample_valid) begin
			gap <= '0;
			seen <= 1'b1;
		end else begin
			gap <= gap + 6'd1;
		end
	end

	a_bresp_hold: assert property (@(posedge clk) disable iff (reset)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else begin $error("write response dropped or changed"); fail_count++; end

	a_rresp_hold: assert property (@(posedge clk) disable iff (reset)
		rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata))
		else begin $error("read response dropped or changed"); fail_count++; end

	a_strobe_width: assert property (@(posedge clk) disable iff (reset)
		sample_valid |=> !sample_valid)
		else begin $error("sample strobe wider than one cycle"); fail_count++; end

	a_strobe_period: assert property (@(posedge clk) disable iff (reset)
		sample_valid && seen |-> gap == 6'd31)
		else begin $error("sample strobe not 32 cycles after the last"); fail_count++; end

	a_quiet_after_reset: assert property (@(posedge clk)
		$fell(reset) |-> !(awready || wready || bvalid || arready || rvalid || sample_valid))
		else begin $error("handshake output high right after reset"); fail_count++; end

endmodule

bind fm_top fm_checker u_checker (.*);

/* dv/fm_tb.sv */
`timescale 1ns/1ns

module fm_tb;
	import fm_pkg::*;

	localparam int max_cycles = 6 * 40 * num_slots + 2000;  // 40 frames per test plus margin

	logic clk = 1'b0;
	logic reset;
	logic [addr_w-1:0] awaddr, araddr;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic [data_w-1:0] wdata, rdata;
	logic [data_w/8-1:0] wstrb;
	logic arvalid, arready, rvalid, rready;
	axi_resp_e bresp, rresp;
	sample_t sample;
	logic sample_valid;

	logic [15:0] lfsr;
	string cur_test;
	int tests, checks, errors, test_errors, cycles;
	sample_t exp_seq [0:7];  // Expected samples from the key-on frame on

	fm_top u_dut (
		.clk, .reset,
		.awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
		.sample, .sample_valid
	);

	always #4 clk = ~clk;

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);  // One step per bit
			v = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic int sine_log(input int i);
		real ang;
		ang = (real'(i) + 0.5) / 256.0 * (3.14159265358979 / 2.0);
		return $rtoi(-$ln($sin(ang)) / $ln(2.0) * 256.0 + 0.5);
	endfunction

	function automatic int exp_mantissa(input int i);
		return $rtoi(8191.0 * $pow(2.0, -real'(i) / 256.0) + 0.5);
	endfunction

	// Unmodulated operator output for one phase and attenuation
	function automatic int op_model(input phase_t p, input att_t a);
		logic [9:0] ph;
		logic [7:0] idx;
		int lg;
		int mag;
		ph = p[19:10];
		idx = ph[8] ? ~ph[7:0] : ph[7:0];  // Mirror the second quarter
		lg = sine_log(idx) + 4 * a;
		mag = (lg / 256 >= 13) ? 0 : exp_mantissa(lg % 256) >> (lg / 256);
		return ph[9] ? -mag : mag;
	endfunction

	function automatic sample_t saturate(input int v);
		if (v > 32767)
			return 16'sh7fff;
		else if (v < -32768)
			return -16'sh8000;
		return sample_t'(v);
	endfunction

	function automatic logic [addr_w-1:0] reg_addr(input reg_kind_e kind, input int idx);
		return {kind, 5'(idx), 2'b00};
	endfunction

	task automatic check_resp(input axi_resp_e exp, input axi_resp_e act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %s actual %s", cur_test, exp.name(), act.name());
		end
	endtask

	task automatic check_data(input logic [data_w-1:0] exp, input logic [data_w-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %h actual %h", cur_test, exp, act);
		end
	endtask

	task automatic check_sample(input sample_t exp, input sample_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s: expected %0d actual %0d", cur_test, exp, act);
		end
	endtask

	// Called on a falling edge and returns on one
	task automatic axi_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data,
			output axi_resp_e resp);
		awaddr = addr;
		wdata = data;
		wstrb = '1;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = 1'b0;
		@(negedge clk);
		while (!awready)
			@(negedge clk);
		checks++;
		if (!wready) begin
			errors++;
			$display("%s: wready not raised together with awready", cur_test);
		end
		awvalid = 1'b0;
		wvalid = 1'b0;
		while (!bvalid)
			@(negedge clk);
		@(negedge clk);  // Response stalled for one cycle
		bready = 1'b1;
		resp = bresp;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data,
			output axi_resp_e resp);
		araddr = addr;
		arvalid = 1'b1;
		rready = 1'b0;
		@(negedge clk);
		while (!arready)
			@(negedge clk);
		arvalid = 1'b0;
		while (!rvalid)
			@(negedge clk);
		@(negedge clk);  // Read data stalled for one cycle
		rready = 1'b1;
		data = rdata;
		resp = rresp;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic write_reg(input reg_kind_e kind, input int idx, input logic [data_w-1:0] data);
		axi_resp_e resp;
		axi_write(reg_addr(kind, idx), data, resp);
		check_resp(resp_okay, resp);
	endtask

	task automatic set_all_att(input att_t a);
		for (int s = 0; s < num_slots; s++)
			write_reg(kind_att, s, data_w'(a));
	endtask

	task automatic key_on(input int ch);
		write_reg(kind_key, ch, '0);
	endtask

	task automatic next_sample(output sample_t s);
		@(negedge clk);
		while (!sample_valid)
			@(negedge clk);
		s = sample;
	endtask

	// Eight samples compared with exp_seq at the first start offset that matches
	task automatic match_sequence(input int max_off);
		sample_t got [0:11];
		int found;
		logic ok;
		found = -1;
		for (int i = 0; i < 8 + max_off; i++)
			next_sample(got[i]);
		for (int o = 0; o <= max_off; o++) begin
			ok = 1'b1;
			for (int j = 0; j < 8; j++)
				if (got[o + j] !== exp_seq[j])
					ok = 1'b0;
			if (ok && found < 0)
				found = o;
		end
		if (found < 0) begin
			errors++;
			$display("%s: sample stream matches at no offset from 0 to %0d", cur_test, max_off);
			found = 0;
		end
		for (int j = 0; j < 8; j++)
			check_sample(exp_seq[j], got[found + j]);
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors = errors;
	endtask

	task automatic end_test;
		tests++;
		if (errors == test_errors)
			$display("%s: ok", cur_test);
		else
			$display("%s: %0d errors", cur_test, errors - test_errors);
	endtask

	task automatic register_access;
		logic [data_w-1:0] d;
		axi_resp_e resp;
		start_test("register_access");
		write_reg(kind_conn, 3, 32'h2e);  // Feedback 5 and connection 6
		axi_read(reg_addr(kind_conn, 3), d, resp);
		check_resp(resp_okay, resp);
		check_data(32'h2e, d);
		write_reg(kind_att, 17, 32'h155);
		axi_read(reg_addr(kind_att, 17), d, resp);
		check_resp(resp_okay, resp);
		check_data(32'h155, d);
		write_reg(kind_inc, 5, 32'habcde);
		axi_read(reg_addr(kind_inc, 5), d, resp);
		check_resp(resp_okay, resp);
		check_data(32'habcde, d);
		axi_write(reg_addr(kind_sample, 0), 32'h1234, resp);  // Read only
		check_resp(resp_slverr, resp);
		axi_read(reg_addr(kind_key, 0), d, resp);  // Write only
		check_resp(resp_slverr, resp);
		end_test();
	endtask

	task automatic silence;
		sample_t s;
		start_test("silence");
		set_all_att(10'h3ff);
		next_sample(s);  // Frames still holding old settings
		next_sample(s);
		for (int j = 0; j < 8; j++) begin
			next_sample(s);
			check_sample(16'sd0, s);
		end
		end_test();
	endtask

	task automatic single_carrier;
		logic [31:0] r;
		phase_t inc;
		start_test("single_carrier");
		set_all_att(10'h3ff);
		write_reg(kind_conn, 0, 32'h7);
		random_bits(20, r);
		inc = r[19:0];
		write_reg(kind_inc, 24, data_w'(inc));  // C2 of channel 0
		write_reg(kind_att, 24, '0);
		key_on(0);
		for (int j = 0; j < 8; j++)
			exp_seq[j] = saturate(op_model(phase_t'(j * inc), '0));
		match_sequence(2);
		end_test();
	endtask

	task automatic additive_carriers;
		logic [31:0] r;
		phase_t inc_a, inc_b;
		start_test("additive_carriers");
		set_all_att(10'h3ff);
		write_reg(kind_conn, 0, 32'h7);  // fb 0
		random_bits(20, r);
		inc_a = r[19:0];
		random_bits(20, r);
		inc_b = r[19:0];
		write_reg(kind_inc, 0, data_w'(inc_a));   // M1
		write_reg(kind_inc, 16, data_w'(inc_b));  // C1
		write_reg(kind_att, 0, '0);
		write_reg(kind_att, 16, 32'd24);
		key_on(0);
		for (int j = 0; j < 8; j++)
			exp_seq[j] = saturate(op_model(phase_t'(j * inc_a), '0)
				+ op_model(phase_t'(j * inc_b), 10'd24));
		match_sequence(2);
		end_test();
	endtask

	task automatic routing;
		logic [31:0] r;
		phase_t inc;
		sample_t s;
		start_test("routing");
		set_all_att(10'h3ff);
		write_reg(kind_conn, 0, 32'h0);
		random_bits(20, r);
		write_reg(kind_inc, 0, data_w'(r[19:0]));
		write_reg(kind_att, 0, '0);  // M1 audible but never a carrier in con 0
		next_sample(s);
		next_sample(s);
		for (int j = 0; j < 8; j++) begin
			next_sample(s);
			check_sample(16'sd0, s);
		end
		set_all_att(10'h3ff);
		write_reg(kind_conn, 0, 32'h28);  // Feedback 5 and connection 0
		random_bits(20, r);
		inc = r[19:0];
		write_reg(kind_inc, 24, data_w'(inc));
		write_reg(kind_att, 24, '0);
		key_on(0);
		for (int j = 0; j < 8; j++)
			exp_seq[j] = saturate(op_model(phase_t'(j * inc), '0));
		match_sequence(2);
		end_test();
	endtask

	task automatic saturation;
		sample_t s;
		start_test("saturation");
		for (int ch = 0; ch < num_ch; ch++)
			write_reg(kind_conn, ch, 32'h7);
		for (int sl = 0; sl < num_slots; sl++)
			write_reg(kind_inc, sl, 32'h40000);  // Quarter wave per frame
		set_all_att('0);
		// Two groups keyed one frame apart with each group inside one frame
		next_sample(s);
		for (int ch = 0; ch < 4; ch++)
			key_on(ch);
		next_sample(s);
		for (int ch = 4; ch < num_ch; ch++)
			key_on(ch);
		for (int j = 0; j < 8; j++)
			exp_seq[j] = saturate(16 * op_model(phase_t'((j + 1) * 'h40000), '0)
				+ 16 * op_model(phase_t'(j * 'h40000), '0));
		match_sequence(3);
		end_test();
	endtask

	initial begin
		cycles = 0;
		while (cycles < max_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: tests still running after %0d cycles", max_cycles);
		$display("test failed");
		$finish;
	end

	initial begin
		int asserts;
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		lfsr = 16'd43;
		tests = 0;
		checks = 0;
		errors = 0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		register_access();
		silence();
		single_carrier();
		additive_carriers();
		routing();
		saturation();
		asserts = u_dut.u_checker.fail_count;
		$display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
			tests, checks, errors, asserts);
		if (errors == 0 && asserts == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* sim.f */
source/fm_pkg.sv
source/fm_regs.sv
source/fm_slot_sequencer.sv
source/fm_delay_line.sv
source/fm_tables.sv
source/fm_operator.sv
source/fm_mixer.sv
source/fm_top.sv
dv/fm_checker.sv
dv/fm_tb.sv

/* Bender.yml */
package:
  name: fm_tone_gen

sources:
  - source/fm_pkg.sv
  - source/fm_regs.sv
  - source/fm_slot_sequencer.sv
  - source/fm_delay_line.sv
  - source/fm_tables.sv
  - source/fm_operator.sv
  - source/fm_mixer.sv
  - source/fm_top.sv
  - target: test
    files:
      - dv/fm_checker.sv
      - dv/fm_tb.sv
